// ==== filelist.f ====
+incdir+include
verilog/fetch_pkg.sv
verilog/fetch_ifs.sv
verilog/pc_gen.sv
verilog/line_fetch.sv
verilog/inst_queue.sv
verilog/fetch_frontend.sv
dv/fetch_checker.sv
dv/tb_fetch_frontend.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/fetch_pkg.sv
      - verilog/fetch_ifs.sv
      - verilog/pc_gen.sv
      - verilog/line_fetch.sv
      - verilog/inst_queue.sv
      - verilog/fetch_frontend.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/fetch_checker.sv
      - dv/tb_fetch_frontend.sv

// ==== dv/tb_fetch_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_config.svh"

module tb_fetch_frontend
import fetch_pkg::*;
();

    localparam int NUM_STEPS     = 16;
    localparam int POP_TIMEOUT   = 100;   // cycles to wait for a queue entry
    localparam int IDLE_WINDOW   = 40;    // tail of a long stall where fetch must be quiet
    localparam int STEP_POP      = 0;
    localparam int STEP_STALL    = 1;
    localparam int STEP_BTB      = 2;
    localparam int STEP_REDIRECT = 3;
    localparam int MEM_IDLE      = 0;
    localparam int MEM_WAIT      = 1;
    localparam int MEM_BEATS     = 2;

    logic   clk;
    logic   rst;
    addr_t  bmem_addr_o;
    logic   bmem_read_o;
    logic   bmem_ready_i;
    beat_t  bmem_rdata_i;
    logic   bmem_rvalid_i;
    logic   redirect_valid_i;
    addr_t  redirect_pc_i;
    logic   btb_update_i;
    addr_t  btb_update_pc_i;
    addr_t  btb_update_target_i;
    logic   deq_i;
    logic   deq_valid_o;
    addr_t  deq_pc_o;
    inst_t  deq_inst_o;
    logic   deq_pred_taken_o;

    logic   expect_idle;
    logic   step_done;
    int     step_idx;
    int     error_count;
    int     pop_count;
    integer seed;
    int     timeouts;
    int     steps_run;
    logic   aborted;
    int     mem_state;
    int     mem_delay;
    int     mem_beat;
    addr_t  mem_line;

    int     step_kind [NUM_STEPS];
    addr_t  step_pc [NUM_STEPS];
    addr_t  step_target [NUM_STEPS];
    int     step_count [NUM_STEPS];

    fetch_frontend DUT (.*);

    fetch_checker u_checker (
        .clk                 (clk),
        .rst                 (rst),
        .bmem_addr_i         (bmem_addr_o),
        .bmem_read_i         (bmem_read_o),
        .bmem_ready_i        (bmem_ready_i),
        .redirect_valid_i    (redirect_valid_i),
        .redirect_pc_i       (redirect_pc_i),
        .btb_update_i        (btb_update_i),
        .btb_update_pc_i     (btb_update_pc_i),
        .btb_update_target_i (btb_update_target_i),
        .deq_i               (deq_i),
        .deq_valid_i         (deq_valid_o),
        .deq_pc_i            (deq_pc_o),
        .deq_inst_i          (deq_inst_o),
        .deq_pred_taken_i    (deq_pred_taken_o),
        .expect_idle_i       (expect_idle),
        .step_done_i         (step_done),
        .step_idx_i          (step_idx),
        .error_count_o       (error_count),
        .pop_count_o         (pop_count)
    );

    always #10 clk = ~clk;

    // each 32-bit word reads back as the inverse of its own byte address
    function automatic beat_t beat_data(input addr_t line, input int beat);
        addr_t lo;
        lo = line + 32'(8 * beat);
        return {~(lo + 32'd4), ~lo};
    endfunction

    // burst memory accepting reads after 0 to 3 cycles and then streaming the line
    always @(posedge clk) begin
        #2;
        bmem_ready_i  = 1'b0;
        bmem_rvalid_i = 1'b0;
        if (rst) begin
            mem_state = MEM_IDLE;
        end else begin
            if (mem_state == MEM_BEATS) begin
                bmem_rvalid_i = 1'b1;
                bmem_rdata_i  = beat_data(mem_line, mem_beat);
                mem_beat++;
                if (mem_beat == `BURST_BEATS) mem_state = MEM_IDLE;
            end else if ((mem_state == MEM_IDLE) && bmem_read_o) begin
                mem_delay = {$random(seed)} % 4;
                mem_state = MEM_WAIT;
            end
            if (mem_state == MEM_WAIT) begin
                if (mem_delay == 0) begin
                    bmem_ready_i = 1'b1;
                    mem_line     = bmem_addr_o;
                    mem_beat     = 0;
                    mem_state    = MEM_BEATS;   // beats start next cycle
                end else begin
                    mem_delay--;
                end
            end
        end
    end

    task automatic set_row(input int i, input int kind, input addr_t pc, input addr_t target,
                           input int count);
        step_kind[i]   = kind;
        step_pc[i]     = pc;
        step_target[i] = target;
        step_count[i]  = count;
    endtask

    task automatic load_table();
        set_row(0, STEP_POP, '0, '0, 12);                          // crosses a line
        set_row(1, STEP_STALL, '0, '0, 150);                       // queue fills
        set_row(2, STEP_POP, '0, '0, 20);
        set_row(3, STEP_REDIRECT, 32'h1eceb400, '0, 0);
        set_row(4, STEP_POP, '0, '0, 10);
        set_row(5, STEP_BTB, 32'h1eceb50c, 32'h1eceb600, 0);
        set_row(6, STEP_BTB, 32'h1eceb610, 32'h1eceb500, 0);       // loop back
        set_row(7, STEP_REDIRECT, 32'h1eceb500, '0, 0);
        set_row(8, STEP_POP, '0, '0, 20);
        set_row(9, STEP_STALL, '0, '0, 150);
        set_row(10, STEP_POP, '0, '0, 16);
        set_row(11, STEP_BTB, 32'h1ecec70c, 32'h1eceb000, 0);      // evicts the 50c entry
        set_row(12, STEP_REDIRECT, 32'h1eceb500, '0, 0);
        set_row(13, STEP_POP, '0, '0, 20);
        set_row(14, STEP_REDIRECT, 32'h1ecec700, '0, 0);
        set_row(15, STEP_POP, '0, '0, 8);
    endtask

    task automatic pop_one(input int step);
        int waited;
        waited = 0;
        while (!deq_valid_o && (waited < POP_TIMEOUT)) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (deq_valid_o) begin
            deq_i = 1'b1;
            @(posedge clk);
            #2;
            deq_i = 1'b0;
        end else begin
            $display("timeout: no instruction to pop within %0d cycles in step %0d",
                     POP_TIMEOUT, step);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    task automatic pop_entries(input int step, input int count);
        int stall;
        for (int i = 0; (i < count) && !aborted; i++) begin
            pop_one(step);
            stall = {$random(seed)} % 4;
            repeat (stall) begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    task automatic hold_off_queue(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            expect_idle = (c >= cycles - IDLE_WINDOW);
            @(posedge clk);
            #2;
        end
        expect_idle = 1'b0;
    endtask

    task automatic run_step(input int s);
        case (step_kind[s])
            STEP_POP:   pop_entries(s, step_count[s]);
            STEP_STALL: hold_off_queue(step_count[s]);
            STEP_BTB: begin
                btb_update_i        = 1'b1;
                btb_update_pc_i     = step_pc[s];
                btb_update_target_i = step_target[s];
                @(posedge clk);
                #2;
                btb_update_i = 1'b0;
            end
            default: begin
                redirect_valid_i = 1'b1;
                redirect_pc_i    = step_pc[s];
                @(posedge clk);
                #2;
                redirect_valid_i = 1'b0;
            end
        endcase
    endtask

    task automatic mark_step_done(input int s);
        step_idx  = s;
        step_done = 1'b1;
        @(posedge clk);
        #2;
        step_done = 1'b0;
    endtask

    initial begin
        clk                 = 1'b0;
        rst                 = 1'b1;
        bmem_ready_i        = 1'b0;
        bmem_rdata_i        = '0;
        bmem_rvalid_i       = 1'b0;
        redirect_valid_i    = 1'b0;
        redirect_pc_i       = '0;
        btb_update_i        = 1'b0;
        btb_update_pc_i     = '0;
        btb_update_target_i = '0;
        deq_i               = 1'b0;
        expect_idle         = 1'b0;
        step_done           = 1'b0;
        step_idx            = 0;
        seed                = 97;
        timeouts            = 0;
        steps_run           = 0;
        aborted             = 1'b0;
        mem_state           = MEM_IDLE;
        load_table();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int s = 0; (s < NUM_STEPS) && !aborted; s++) begin
            run_step(s);
            if (!aborted) begin
                mark_step_done(s);
                steps_run++;
            end
        end
        repeat (4) @(posedge clk);
        $display("steps %0d of %0d, pops checked %0d, errors %0d, timeouts %0d",
                 steps_run, NUM_STEPS, pop_count, error_count, timeouts);
        if ((error_count == 0) && (timeouts == 0)) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/fetch_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_config.svh"

module fetch_checker
import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  addr_t bmem_addr_i,
    input  logic  bmem_read_i,
    input  logic  bmem_ready_i,
    input  logic  redirect_valid_i,
    input  addr_t redirect_pc_i,
    input  logic  btb_update_i,
    input  addr_t btb_update_pc_i,
    input  addr_t btb_update_target_i,
    input  logic  deq_i,
    input  logic  deq_valid_i,
    input  addr_t deq_pc_i,
    input  inst_t deq_inst_i,
    input  logic  deq_pred_taken_i,
    input  logic  expect_idle_i,   // queue should be full and fetch quiet
    input  logic  step_done_i,
    input  int    step_idx_i,
    output int    error_count_o,
    output int    pop_count_o
);

    localparam int BTB_ENTRIES = 1 << `BTB_INDEX_BITS;
    localparam int LINE_BYTES  = `LINE_BITS / 8;

    addr_t model_pc [BTB_ENTRIES];
    addr_t model_target [BTB_ENTRIES];
    logic  model_vld [BTB_ENTRIES];
    logic  btb_used;        // lines stop being strictly sequential once any entry is written
    addr_t exp_pc;
    addr_t last_line;
    logic  last_line_vld;
    logic  skip_accept;     // stale burst still to be accepted after a redirect
    logic  reset_seen;
    int    step_errors;

    // direct mapped on word address
    function automatic int btb_slot(input addr_t pc);
        return (pc >> 2) % BTB_ENTRIES;
    endfunction

    function automatic logic predicts(input addr_t pc);
        return model_vld[btb_slot(pc)] && (model_pc[btb_slot(pc)] == pc);
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        error_count_o++;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, got %h", name, expected, actual);
            error_count_o++;
        end
    endtask

    task automatic check_fetch_line(input addr_t addr);
        check_value("bmem_addr_o", addr & ~(LINE_BYTES - 1), addr);
        if (skip_accept) begin
            skip_accept = 1'b0;
        end else begin
            if (last_line_vld && !btb_used) begin
                check_value("bmem_addr_o", last_line + LINE_BYTES, addr);
            end else if (last_line_vld && (addr == last_line)) begin
                report_error($sformatf("line %h read twice in a row", addr));
            end
            last_line     = addr;
            last_line_vld = 1'b1;
        end
    endtask

    initial begin
        error_count_o = 0;
        pop_count_o   = 0;
        step_errors   = 0;
        reset_seen    = 1'b0;
        btb_used      = 1'b0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            model_vld[i] = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            reset_seen    = 1'b1;
            exp_pc        = `FETCH_RESET_PC;
            last_line     = (`FETCH_RESET_PC & ~(LINE_BYTES - 1)) - LINE_BYTES;
            last_line_vld = 1'b1;   // first read must be the reset line
            skip_accept   = 1'b0;
        end else begin
            if (reset_seen) begin
                reset_seen = 1'b0;
                if (bmem_read_i) report_error("bmem_read_o high right after reset");
                if (deq_valid_i) report_error("deq_valid_o high right after reset");
            end
            if (deq_i && deq_valid_i && !redirect_valid_i) begin
                check_value("deq_pc_o", exp_pc, deq_pc_i);
                check_value("deq_inst_o", ~exp_pc, deq_inst_i);
                check_value("deq_pred_taken_o", {31'b0, predicts(exp_pc)},
                            {31'b0, deq_pred_taken_i});
                pop_count_o++;
                exp_pc = predicts(exp_pc) ? model_target[btb_slot(exp_pc)] : exp_pc + 32'd4;
            end
            if (bmem_read_i && bmem_ready_i) begin
                check_fetch_line(bmem_addr_i);
            end
            if (redirect_valid_i) begin
                exp_pc        = redirect_pc_i;
                skip_accept   = bmem_read_i && !bmem_ready_i;
                last_line_vld = 1'b0;
            end
            if (btb_update_i) begin
                model_pc[btb_slot(btb_update_pc_i)]     = btb_update_pc_i;
                model_target[btb_slot(btb_update_pc_i)] = btb_update_target_i;
                model_vld[btb_slot(btb_update_pc_i)]    = 1'b1;
                btb_used = 1'b1;
            end
            if (expect_idle_i) begin
                if (bmem_read_i) report_error("memory read requested with the queue full");
                if (!deq_valid_i) report_error("queue empty during a long stall");
            end
            if (step_done_i) begin
                if (error_count_o == step_errors) begin
                    $display("step %0d: ok", step_idx_i);
                end else begin
                    $display("step %0d: %0d errors", step_idx_i, error_count_o - step_errors);
                end
                step_errors = error_count_o;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/fetch_frontend.sv ====
`timescale 1ns/10ps
`default_nettype none

module fetch_frontend
import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    output addr_t bmem_addr_o,
    output logic  bmem_read_o,
    input  logic  bmem_ready_i,
    input  beat_t bmem_rdata_i,
    input  logic  bmem_rvalid_i,

    input  logic  redirect_valid_i,
    input  addr_t redirect_pc_i,
    input  logic  btb_update_i,
    input  addr_t btb_update_pc_i,
    input  addr_t btb_update_target_i,

    input  logic  deq_i,
    output logic  deq_valid_o,
    output addr_t deq_pc_o,
    output inst_t deq_inst_o,
    output logic  deq_pred_taken_o
);

    fetch_req_if  req_if ();    // pc gen to line fetch
    fetch_word_if word_if ();   // line fetch to queue, credits back to pc gen

    pc_gen u_pc_gen (
        .clk                 (clk),
        .rst                 (rst),
        .redirect_valid_i    (redirect_valid_i),
        .redirect_pc_i       (redirect_pc_i),
        .btb_update_i        (btb_update_i),
        .btb_update_pc_i     (btb_update_pc_i),
        .btb_update_target_i (btb_update_target_i),
        .req                 (req_if),
        .credit              (word_if)
    );

    line_fetch u_line_fetch (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .req              (req_if),
        .word             (word_if),
        .bmem_addr_o      (bmem_addr_o),
        .bmem_read_o      (bmem_read_o),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_rvalid_i    (bmem_rvalid_i)
    );

    inst_queue u_inst_queue (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .word             (word_if),
        .deq_i            (deq_i),
        .deq_valid_o      (deq_valid_o),
        .deq_pc_o         (deq_pc_o),
        .deq_inst_o       (deq_inst_o),
        .deq_pred_taken_o (deq_pred_taken_o)
    );

endmodule

`default_nettype wire

// ==== verilog/inst_queue.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_config.svh"

module inst_queue
import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid_i,
    fetch_word_if.sink  word,
    input  logic        deq_i,
    output logic        deq_valid_o,
    output addr_t       deq_pc_o,
    output inst_t       deq_inst_o,
    output logic        deq_pred_taken_o
);

    localparam int PTR_BITS = $clog2(`IQ_DEPTH);
    localparam int CNT_BITS = $clog2(`IQ_DEPTH + 1);

    addr_t                pc_mem [`IQ_DEPTH];
    inst_t                inst_mem [`IQ_DEPTH];
    logic [`IQ_DEPTH-1:0] pred_mem;
    logic [PTR_BITS-1:0]  head_q;
    logic [PTR_BITS-1:0]  tail_q;
    logic [CNT_BITS-1:0]  count_q;
    logic                 push;
    logic                 pop;

    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(`IQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign push = word.word_valid && !redirect_valid_i;   // words under a flush are stale
    assign pop  = deq_i && deq_valid_o;

    // show-ahead head entry
    assign deq_valid_o      = (count_q != '0);
    assign deq_pc_o         = pc_mem[head_q];
    assign deq_inst_o       = inst_mem[head_q];
    assign deq_pred_taken_o = pred_mem[head_q];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q             <= '0;
            tail_q             <= '0;
            count_q            <= '0;
            word.credit_return <= 1'b0;
        end else if (redirect_valid_i) begin
            head_q             <= '0;
            tail_q             <= '0;
            count_q            <= '0;
            word.credit_return <= 1'b0;   // pc gen refills its pool on redirect
        end else begin
            if (push) begin
                tail_q <= ptr_inc(tail_q);
            end
            if (pop) begin
                head_q <= ptr_inc(head_q);
            end
            count_q            <= count_q + CNT_BITS'(push) - CNT_BITS'(pop);
            word.credit_return <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[tail_q]   <= word.word_pc;
            inst_mem[tail_q] <= word.word_inst;
            pred_mem[tail_q] <= word.word_pred_taken;
        end
    end

    // credits in pc gen must keep pushes off a full queue
    assert property (@(posedge clk) disable iff (rst)
        push |-> count_q != CNT_BITS'(`IQ_DEPTH))
        else $error("instruction queue push while full");

    assert property (@(posedge clk) disable iff (rst)
        deq_i |-> deq_valid_o)
        else $error("instruction queue pop while empty");

endmodule

`default_nettype wire

// ==== verilog/line_fetch.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_config.svh"

module line_fetch
import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        redirect_valid_i,
    fetch_req_if.sink   req,
    fetch_word_if.source word,
    output addr_t       bmem_addr_o,
    output logic        bmem_read_o,
    input  logic        bmem_ready_i,
    input  beat_t       bmem_rdata_i,
    input  logic        bmem_rvalid_i
);

    localparam int BEAT_BITS = $bits(beat_t);
    localparam int WORD_BITS = $bits(inst_t);
    localparam int OFFS_BITS = $clog2(`LINE_BITS / 8);
    localparam int WSEL_BITS = $clog2(`LINE_BITS / WORD_BITS);
    localparam int CNT_BITS  = $clog2(`BURST_BEATS);

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_REQ   = 2'd1;   // waiting for bmem_ready_i
    localparam logic [1:0] ST_BEATS = 2'd2;   // gathering the burst

    logic [1:0]              state_q;
    line_t                   line_buf;
    line_t                   line_next;
    logic [31-OFFS_BITS:0]   line_tag_q;
    logic                    line_vld_q;
    addr_t                   pend_pc_q;
    logic                    pend_pred_q;
    logic                    drop_q;      // pending word belongs to a flushed path
    logic [CNT_BITS-1:0]     beat_cnt_q;
    logic                    take;
    logic                    hit;
    logic                    beat_we;
    logic                    last_beat;
    logic [WSEL_BITS-1:0]    word_sel;

    assign req.req_busy = (state_q != ST_IDLE);
    assign take         = req.req_valid && !req.req_busy;
    assign hit          = line_vld_q && (line_tag_q == req.req_pc[31:OFFS_BITS]);
    assign beat_we      = (state_q == ST_BEATS) && bmem_rvalid_i;
    assign last_beat    = beat_we && (beat_cnt_q == CNT_BITS'(`BURST_BEATS - 1));
    assign word_sel     = (state_q == ST_IDLE) ? req.req_pc[OFFS_BITS-1:2]
                                               : pend_pc_q[OFFS_BITS-1:2];

    // buffered line with the incoming beat merged in, equals line_buf when idle
    always_comb begin
        line_next = line_buf;
        if (beat_we) begin
            line_next[beat_cnt_q*BEAT_BITS +: BEAT_BITS] = bmem_rdata_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q         <= ST_IDLE;
            bmem_read_o     <= 1'b0;
            line_vld_q      <= 1'b0;
            drop_q          <= 1'b0;
            beat_cnt_q      <= '0;
            word.word_valid <= 1'b0;
        end else begin
            word.word_valid <= 1'b0;
            if (redirect_valid_i) begin
                drop_q <= 1'b1;
            end
            case (state_q)
                ST_IDLE: begin
                    if (take && hit) begin
                        word.word_valid <= 1'b1;
                    end else if (take) begin
                        state_q     <= ST_REQ;
                        bmem_read_o <= 1'b1;
                        line_vld_q  <= 1'b0;   // line is about to be overwritten
                        drop_q      <= 1'b0;
                    end
                end
                ST_REQ: begin
                    if (bmem_ready_i) begin
                        bmem_read_o <= 1'b0;
                        beat_cnt_q  <= '0;
                        state_q     <= ST_BEATS;
                    end
                end
                ST_BEATS: begin
                    if (beat_we) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                    end
                    if (last_beat) begin
                        state_q         <= ST_IDLE;
                        line_vld_q      <= 1'b1;   // fill completes even after a flush
                        word.word_valid <= !drop_q && !redirect_valid_i;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state_q == ST_IDLE) && take && !hit) begin
            bmem_addr_o <= {req.req_pc[31:OFFS_BITS], {OFFS_BITS{1'b0}}};
            line_tag_q  <= req.req_pc[31:OFFS_BITS];
            pend_pc_q   <= req.req_pc;
            pend_pred_q <= req.req_pred_taken;
        end
        if (beat_we) begin
            line_buf <= line_next;
        end
        word.word_pc         <= (state_q == ST_IDLE) ? req.req_pc : pend_pc_q;
        word.word_pred_taken <= (state_q == ST_IDLE) ? req.req_pred_taken : pend_pred_q;
        word.word_inst       <= line_next[word_sel*WORD_BITS +: WORD_BITS];
    end

    assert property (@(posedge clk) disable iff (rst)
        bmem_read_o && !bmem_ready_i |=> bmem_read_o && $stable(bmem_addr_o))
        else $error("bmem read request changed before bmem_ready_i");

endmodule

`default_nettype wire

// ==== verilog/pc_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "fetch_config.svh"

module pc_gen
import fetch_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              redirect_valid_i,
    input  addr_t             redirect_pc_i,
    input  logic              btb_update_i,
    input  addr_t             btb_update_pc_i,
    input  addr_t             btb_update_target_i,
    fetch_req_if.source       req,
    fetch_word_if.credit_sink credit
);

    localparam int BTB_ENTRIES = 1 << `BTB_INDEX_BITS;
    localparam int TAG_LSB     = `BTB_INDEX_BITS + 2;
    localparam int TAG_BITS    = $bits(addr_t) - TAG_LSB;
    localparam int CREDIT_BITS = $clog2(`IQ_DEPTH + 1);

    addr_t                      pc_q;
    addr_t                      pc_next;
    logic                       fetch_en_q;
    logic [CREDIT_BITS-1:0]     credit_cnt;
    logic [CREDIT_BITS-1:0]     credit_next;
    logic                       issue;

    logic [TAG_BITS-1:0]        btb_tag [BTB_ENTRIES];
    addr_t                      btb_target [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0]     btb_vld;

    logic [`BTB_INDEX_BITS-1:0] lookup_idx;
    logic [`BTB_INDEX_BITS-1:0] update_idx;
    logic                       btb_hit;

    assign lookup_idx = pc_q[TAG_LSB-1:2];
    assign update_idx = btb_update_pc_i[TAG_LSB-1:2];
    assign btb_hit    = btb_vld[lookup_idx] && (btb_tag[lookup_idx] == pc_q[31:TAG_LSB]);
    assign pc_next    = btb_hit ? btb_target[lookup_idx] : pc_q + 32'd4;

    // a request costs one queue slot, never issued under a redirect
    assign req.req_valid      = fetch_en_q && (credit_cnt != '0) && !redirect_valid_i;
    assign req.req_pc         = pc_q;
    assign req.req_pred_taken = btb_hit;
    assign issue              = req.req_valid && !req.req_busy;

    assign credit_next = credit_cnt - CREDIT_BITS'(issue) + CREDIT_BITS'(credit.credit_return);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q       <= `FETCH_RESET_PC;
            fetch_en_q <= 1'b0;   // idle for the first cycle out of reset
            credit_cnt <= CREDIT_BITS'(`IQ_DEPTH);
            btb_vld    <= '0;
        end else begin
            fetch_en_q <= 1'b1;
            if (redirect_valid_i) begin
                pc_q       <= redirect_pc_i;
                credit_cnt <= CREDIT_BITS'(`IQ_DEPTH);   // queue and in-flight words are gone
            end else begin
                if (issue) begin
                    pc_q <= pc_next;
                end
                credit_cnt <= credit_next;
            end
            if (btb_update_i) begin
                btb_vld[update_idx] <= 1'b1;
            end
        end
    end

    // tag and target arrays, qualified by btb_vld
    always_ff @(posedge clk) begin
        if (btb_update_i) begin
            btb_tag[update_idx]    <= btb_update_pc_i[31:TAG_LSB];
            btb_target[update_idx] <= btb_update_target_i;
        end
    end

    // queue returns exactly what was spent, so the pool never grows
    assert property (@(posedge clk) disable iff (rst)
        credit_cnt <= CREDIT_BITS'(`IQ_DEPTH))
        else $error("fetch credit count above queue depth");

endmodule

`default_nettype wire

// ==== verilog/fetch_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

// fetch request from pc gen into the line fetch stage
interface fetch_req_if
import fetch_pkg::*;
();
    logic  req_valid;
    addr_t req_pc;
    logic  req_pred_taken;   // btb hit on req_pc
    logic  req_busy;         // line fetch cannot take a request

    modport source (output req_valid, output req_pc, output req_pred_taken, input req_busy);
    modport sink (input req_valid, input req_pc, input req_pred_taken, output req_busy);
endinterface

// fetched word into the queue, credits back to pc gen
interface fetch_word_if
import fetch_pkg::*;
();
    logic  word_valid;
    addr_t word_pc;
    inst_t word_inst;
    logic  word_pred_taken;
    logic  credit_return;    // one pulse per popped entry

    modport source (
        output word_valid,
        output word_pc,
        output word_inst,
        output word_pred_taken
    );
    modport sink (
        input  word_valid,
        input  word_pc,
        input  word_inst,
        input  word_pred_taken,
        output credit_return
    );
    modport credit_sink (input credit_return);
endinterface

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
`default_nettype none

`include "fetch_config.svh"

package fetch_pkg;

    // byte address seen by pc gen, line buffer and memory
    typedef logic [31:0] addr_t;

    // raw rv32i instruction word
    typedef logic [31:0] inst_t;

    // one memory beat, a line split into BURST_BEATS pieces
    typedef logic [`LINE_BITS/`BURST_BEATS-1:0] beat_t;

    // full cache line, beat 0 in the low bits
    typedef logic [`LINE_BITS-1:0] line_t;

endpackage

`default_nettype wire

// ==== include/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// fetch front end build parameters

// first instruction fetched out of reset
`define FETCH_RESET_PC 32'h1eceb000

// btb size as log2 of entry count, indexed by pc[7:2] at 6
`define BTB_INDEX_BITS 6

// instruction queue entries, also the credit pool size
`define IQ_DEPTH 8

// memory burst shape
`define BURST_BEATS 4   // beats per line
`define LINE_BITS 256   // 8 words per line

`endif
